//--- rtl/link_8b9b_pkg.sv
package link_8b9b_pkg;

	// Link format
	localparam int word_width = 8;         // Data bits per word
	localparam int samples_per_bit = 4;    // Line samples per clk cycle
	localparam int min_idle_bits = 7;      // Sync gap of high bits ahead of every frame

	// Block sizes
	localparam int tx_queue_depth = 8;
	localparam int rx_reset_hold = 4;      // Receiver stays in reset this long after reset falls

	// Counter and index widths
	localparam int queue_ptr_width = $clog2(tx_queue_depth);
	localparam int queue_cnt_width = $clog2(tx_queue_depth + 1);
	localparam int bit_cnt_width = $clog2(word_width + 1);
	localparam int idle_cnt_width = $clog2(min_idle_bits + 1);
	localparam int sample_idx_width = $clog2(samples_per_bit);

	// Receiver word assembly
	typedef enum logic [1:0] {
		idle    = 2'b00,    // Waiting for the start edge
		once    = 2'b01,    // First data bit still in the pipeline
		receive = 2'b10,    // Shifting in data bits
		commit  = 2'b11     // Word out and marker check
	} rx_state_t;

endpackage

//--- rtl/tx_word_if.sv
interface tx_word_if import link_8b9b_pkg::*; ();

	logic [word_width-1:0] word;    // Head entry data
	logic                  last;    // Head entry closes its frame
	logic                  empty;   // Nothing queued
	logic                  read;    // One-cycle pop strobe

	// Queue side owns the head entry
	modport queue (
		output word,
		output last,
		output empty,
		input  read
	);

	// Framer side only pops
	modport framer (
		input  word,
		input  last,
		input  empty,
		output read
	);

endinterface

//--- rtl/tx_word_queue.sv
module tx_word_queue import link_8b9b_pkg::*; (
	input  logic                  clk,
	input  logic                  async_reset,
	input  logic [word_width-1:0] word,
	input  logic                  last,
	input  logic                  write,
	output logic                  full,
	tx_word_if.queue              q
);

	logic [word_width:0]        mem [tx_queue_depth];  // {last, word} per entry
	logic [queue_ptr_width-1:0] wr_ptr;
	logic [queue_ptr_width-1:0] rd_ptr;
	logic [queue_cnt_width-1:0] count;                 // Entries held
	logic                       push;
	logic                       pop;

	// Step a pointer round the ring
	function automatic logic [queue_ptr_width-1:0] next_ptr(
		input logic [queue_ptr_width-1:0] ptr
	);
		if (ptr == queue_ptr_width'(tx_queue_depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign push = write && !full;       // A write into a full queue is lost
	assign pop  = q.read && !q.empty;

	// Flags straight from the count
	assign full    = (count == queue_cnt_width'(tx_queue_depth));
	assign q.empty = (count == '0);

	// Head entry shown to the framer
	assign {q.last, q.word} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= {last, word};
	end

	always_ff @(posedge clk) begin
		if (async_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);   // Next entry visible a cycle later
			// Push and pop together leave the count alone
			count <= count + queue_cnt_width'(push) - queue_cnt_width'(pop);
		end
	end

endmodule

//--- rtl/tx_framer_8b9b.sv
module tx_framer_8b9b import link_8b9b_pkg::*; (
	input  logic      clk,
	input  logic      async_reset,
	tx_word_if.framer q,
	output logic      line
);

	logic [word_width:0]       shift;      // Marker in bit 0 with the data above it
	logic [bit_cnt_width-1:0]  bit_cnt;    // Bits still to follow the one on the line
	logic [idle_cnt_width-1:0] gap_cnt;    // High bits sent since the last frame
	logic                      active;     // Marker or data bit on the line
	logic                      in_frame;   // Opening marker sent and frame not closed
	logic                      word_last;  // Last flag of the word on the line
	logic                      word_end;
	logic                      gap_done;

	// Line driven straight off the shifter which holds all ones when idle
	assign line = shift[0];

	assign word_end = active && (bit_cnt == '0);    // Last data bit going out
	assign gap_done = (gap_cnt == idle_cnt_width'(min_idle_bits));

	// Pop when the next marker can go out on the following bit
	// Back to back inside a frame and after the gap for a new one
	assign q.read = !q.empty &&
		(word_end ? !word_last : (!active && (in_frame || gap_done)));

	always_ff @(posedge clk) begin
		if (async_reset) begin
			shift     <= '1;               // Line idles high
			bit_cnt   <= '0;
			gap_cnt   <= '0;
			active    <= 1'b0;
			in_frame  <= 1'b0;
			word_last <= 1'b0;
		end else if (q.read) begin
			// Word loaded behind a 0 marker that opens or continues the frame
			shift     <= {q.word, 1'b0};
			bit_cnt   <= bit_cnt_width'(word_width);
			word_last <= q.last;
			active    <= 1'b1;
			in_frame  <= 1'b1;
			gap_cnt   <= '0;
		end else if (active) begin
			shift <= {1'b1, shift[word_width:1]};   // LSB first with ones filling behind
			if (word_end) begin
				active <= 1'b0;
				if (word_last) begin
					// The closing 1 counts as the first idle bit
					in_frame <= 1'b0;
					gap_cnt  <= idle_cnt_width'(1);
				end
				// Otherwise the queue ran dry and the line holds high until a word arrives
			end else begin
				bit_cnt <= bit_cnt - 1'b1;
			end
		end else if (!in_frame && !gap_done) begin
			gap_cnt <= gap_cnt + 1'b1;     // Counting out the sync gap
		end
	end

endmodule

//--- rtl/oversampling_rx_8b9b.sv
module oversampling_rx_8b9b import link_8b9b_pkg::*; (
	input  logic                       clk,
	input  logic                       async_reset,
	input  logic                       enable,
	input  logic [samples_per_bit-1:0] samples,
	output logic [word_width-1:0]      word_out,
	output logic                       word_write,
	output logic                       frame_complete
);

	logic [rx_reset_hold-1:0]    hold_sr;          // Reset stretch
	logic                        hold_reset;
	logic [samples_per_bit-1:0]  int_data;         // Bit 0 is the earliest sample
	logic [samples_per_bit-1:0]  r_int_data;       // Previous nibble
	logic                        n_start_detect;   // Low when the nibble held a low sample
	logic [sample_idx_width-1:0] first_low;
	logic [sample_idx_width-1:0] int_latch_point;
	logic [sample_idx_width-1:0] latch_point;      // Locked once per frame
	logic                        int_bit;          // Recovered line bit
	logic [word_width-1:0]       int_result;
	logic [bit_cnt_width-1:0]    bit_counter;
	rx_state_t                   state;

	// Keep the receiver in reset a few cycles past the external reset
	always_ff @(posedge clk) begin
		if (async_reset)
			hold_sr <= '1;
		else
			hold_sr <= hold_sr << 1;
	end

	assign hold_reset = hold_sr[rx_reset_hold-1];

	// Earliest low sample in the nibble
	always_comb begin
		first_low = '0;
		for (int i = samples_per_bit - 1; i >= 0; i--) begin
			if (!int_data[i])
				first_low = sample_idx_width'(i);
		end
	end

	// Sample pipeline
	always_ff @(posedge clk) begin
		int_data       <= samples;
		r_int_data     <= int_data;
		n_start_detect <= &int_data;
		// Step one sample past the edge and wrap into the next nibble
		int_latch_point <= first_low + 1'b1;
		// Point 0 sits a nibble later than the rest
		// Taking it from the current nibble lines all phases up in one cycle
		int_bit <= (latch_point == '0) ? int_data[0] : r_int_data[latch_point];
	end

	// Word assembly
	always_ff @(posedge clk) begin
		if (hold_reset) begin
			state          <= idle;
			latch_point    <= '0;
			bit_counter    <= '0;
			word_write     <= 1'b0;
			frame_complete <= 1'b0;
		end else begin
			word_write     <= 1'b0;     // Strobes last one cycle
			frame_complete <= 1'b0;
			case (state)
				idle: begin
					// Enable only counts here so a frame always runs to its end
					if (enable && !n_start_detect) begin
						latch_point <= int_latch_point;
						bit_counter <= bit_cnt_width'(word_width - 1);
						state       <= once;
					end
				end
				once: begin
					state <= receive;     // int_bit catches up with the new phase
				end
				receive: begin
					bit_counter <= bit_counter - 1'b1;
					if (bit_counter == '0)
						state <= commit;
				end
				commit: begin
					word_write  <= 1'b1;
					bit_counter <= bit_cnt_width'(word_width - 1);
					// int_bit now holds the marker
					if (int_bit) begin
						frame_complete <= 1'b1;
						state          <= idle;
					end else begin
						state <= receive;     // Another word follows
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Data shifter and output word
	always_ff @(posedge clk) begin
		if (state == receive)
			int_result <= {int_bit, int_result[word_width-1:1]};   // LSB arrives first
		if (state == commit)
			word_out <= int_result;
	end

endmodule

//--- rtl/link_8b9b_top.sv
module link_8b9b_top import link_8b9b_pkg::*; (
	input  logic                       clk,
	input  logic                       async_reset,
	input  logic [word_width-1:0]      tx_word,
	input  logic                       tx_last,
	input  logic                       tx_write,
	input  logic                       rx_enable,
	input  logic [samples_per_bit-1:0] rx_samples,
	output logic                       tx_full,
	output logic                       tx_line,
	output logic [word_width-1:0]      rx_word,
	output logic                       rx_word_write,
	output logic                       rx_frame_complete
);

	// Queue head to framer
	tx_word_if u_word_if ();

	// Transmit side
	tx_word_queue u_queue (
		.clk         (clk),
		.async_reset (async_reset),
		.word        (tx_word),
		.last        (tx_last),
		.write       (tx_write),
		.full        (tx_full),
		.q           (u_word_if.queue)
	);

	tx_framer_8b9b u_framer (
		.clk         (clk),
		.async_reset (async_reset),
		.q           (u_word_if.framer),
		.line        (tx_line)
	);

	// Receive side runs off the sampled line
	oversampling_rx_8b9b u_rx (
		.clk            (clk),
		.async_reset    (async_reset),
		.enable         (rx_enable),
		.samples        (rx_samples),
		.word_out       (rx_word),
		.word_write     (rx_word_write),
		.frame_complete (rx_frame_complete)
	);

endmodule

//--- bench/link_8b9b_asserts.sv
module link_8b9b_asserts import link_8b9b_pkg::*; (
	input logic      clk,
	input logic      async_reset,
	input logic      hold_reset,
	input rx_state_t state,
	input logic      word_write,
	input logic      frame_complete
);

	// Frame end always comes with a word
	complete_with_write: assert property (@(posedge clk) disable iff (async_reset || hold_reset)
		frame_complete |-> word_write)
		else $error("frame_complete without word_write");

	// Words are at least a marker and a data field apart
	write_single_cycle: assert property (@(posedge clk) disable iff (async_reset || hold_reset)
		word_write |=> !word_write)
		else $error("word_write high in two consecutive cycles");

	// No word assembly during the hold-off
	idle_in_hold: assert property (@(posedge clk) disable iff (async_reset)
		hold_reset |-> !(state inside {once, receive}))
		else $error("receiver left idle during reset hold-off");

endmodule

//--- bench/link_8b9b_checker.sv
module link_8b9b_checker import link_8b9b_pkg::*; (
	input  logic                  clk,
	input  logic                  async_reset,
	input  logic [word_width-1:0] tx_word,
	input  logic                  tx_last,
	input  logic                  tx_write,
	input  logic                  tx_full,
	input  logic                  tx_line,
	input  logic                  rx_enable,
	input  logic [word_width-1:0] rx_word,
	input  logic                  rx_word_write,
	input  logic                  rx_frame_complete,
	input  int                    phase,
	output int                    check_errors,
	output int                    pending
);

	logic [word_width:0] model [$];   // {last, word} in line order
	logic [word_width:0] head;
	logic                started;     // First word accepted by the queue

	function automatic string test_name(input int p);
		case (p)
			1: return "single_word";
			2: return "multi_word";
			3: return "every_delay";
			4: return "queue_full";
			5: return "rx_disabled";
			default: return "after_reset";
		endcase
	endfunction

	initial begin
		check_errors = 0;
		pending = 0;
		started = 1'b0;
	end

	always @(posedge clk) begin
		if (!async_reset) begin
			// Link stays quiet until the first write
			if (!started && (tx_line !== 1'b1 || rx_word_write !== 1'b0 ||
					rx_frame_complete !== 1'b0)) begin
				check_errors++;
				$display("Link not quiet after reset although nothing was written");
			end
			if (rx_word_write === 1'b1) begin
				if (model.size() == 0) begin
					check_errors++;
					$display("%s: receiver wrote %h with no word expected",
						test_name(phase), rx_word);
				end else begin
					head = model.pop_front();
					if (rx_word !== head[word_width-1:0]) begin
						check_errors++;
						$display("[ERROR] %s: rx_word expected %h, actual %h",
							test_name(phase), head[word_width-1:0], rx_word);
					end
					if (rx_frame_complete !== head[word_width]) begin
						check_errors++;
						$display("[ERROR] %s: rx_frame_complete expected %b, actual %b",
							test_name(phase), head[word_width], rx_frame_complete);
					end
				end
			end
			if (tx_write && !tx_full) begin
				started = 1'b1;
				if (rx_enable)
					model.push_back({tx_last, tx_word});   // Only enabled frames reach the output
			end
			pending = model.size();
		end
	end

endmodule

//--- bench/link_8b9b_tb.sv
module link_8b9b_tb import link_8b9b_pkg::*; ();

	localparam int quiet_cycles = 20;     // Longer than any run of ones with a word queued
	localparam int wait_limit = 2000;

	logic                       clk;
	logic                       async_reset;
	logic [word_width-1:0]      tx_word;
	logic                       tx_last;
	logic                       tx_write;
	logic                       rx_enable;
	logic [samples_per_bit-1:0] rx_samples;
	logic                       tx_full;
	logic                       tx_line;
	logic [word_width-1:0]      rx_word;
	logic                       rx_word_write;
	logic                       rx_frame_complete;
	logic                       prev_line;     // Line bit of the previous cycle
	int                         delay;         // Channel delay in samples
	integer                     seed;
	int                         phase;
	int                         errors;
	int                         check_errors;
	int                         pending;
	int                         full_seen;     // Cycles spent waiting on tx_full
	bit                         timed_out;

	always #5 clk = ~clk;

	// Channel model where the first delay samples of a cycle still carry the previous bit
	always @(posedge clk) begin
		for (int i = 0; i < samples_per_bit; i++)
			rx_samples[i] <= (i >= delay) ? tx_line : prev_line;
		prev_line <= tx_line;
	end

	link_8b9b_top u_link_8b9b_top (.*);

	link_8b9b_checker u_checker (.*);

	bind oversampling_rx_8b9b link_8b9b_asserts u_asserts (.*);

	task automatic count_wait(inout int t, input string what);
		t++;
		if (t > wait_limit && !timed_out) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout while waiting, %s", what);
		end
	endtask

	// Queue empty and receiver back in idle once the line stays high long enough
	task automatic wait_quiet();
		int run;
		int t;
		run = 0;
		t = 0;
		while (run < quiet_cycles && !timed_out) begin
			@(posedge clk);
			run = (tx_line === 1'b1) ? run + 1 : 0;
			count_wait(t, "transmit line never went idle");
		end
	endtask

	task automatic push_word(input logic [word_width-1:0] w, input logic l);
		int t;
		t = 0;
		@(posedge clk);
		while (tx_full && !timed_out) begin
			full_seen++;
			count_wait(t, "tx_full stayed high");
			@(posedge clk);
		end
		if (!timed_out) begin
			tx_word  <= w;
			tx_last  <= l;
			tx_write <= 1'b1;
			@(posedge clk);
			tx_write <= 1'b0;      // Full flag settles before the next word
		end
	endtask

	task automatic send_frame(input int n);
		for (int i = 0; i < n; i++)
			push_word(word_width'($random(seed)), i == n - 1);
	endtask

	// Negative d picks a random delay for the next frame
	task automatic idle_frame(input int n, input int d);
		wait_quiet();
		delay <= (d < 0) ? $unsigned($random(seed)) % samples_per_bit : d;
		send_frame(n);
	endtask

	initial begin
		seed = 32'h2e5f;
		clk = 1'b0;
		async_reset = 1'b1;
		tx_word = '0;
		tx_last = 1'b0;
		tx_write = 1'b0;
		rx_enable = 1'b1;
		rx_samples = '1;
		prev_line = 1'b1;
		delay = 0;
		phase = 0;
		errors = 0;
		full_seen = 0;
		timed_out = 1'b0;
		repeat (3) @(posedge clk);
		async_reset <= 1'b0;
		wait_quiet();          // Nothing may come out before the first write
		phase <= 1;
		repeat (6) idle_frame(1, -1);
		phase <= 2;
		repeat (6) idle_frame(2 + $unsigned($random(seed)) % 3, -1);
		phase <= 3;
		for (int d = 0; d < samples_per_bit; d++)
			repeat (3) idle_frame(1 + $unsigned($random(seed)) % 4, d);
		wait_quiet();
		phase <= 4;            // Back to back frames fill the queue
		repeat (10) send_frame(1 + $unsigned($random(seed)) % 4);
		wait_quiet();
		phase <= 5;
		rx_enable <= 1'b0;     // Line idle and queue empty here
		repeat (3) idle_frame(1 + $unsigned($random(seed)) % 4, -1);
		wait_quiet();
		rx_enable <= 1'b1;
		repeat (3) idle_frame(1 + $unsigned($random(seed)) % 4, -1);
		wait_quiet();
		if (full_seen == 0) begin
			errors++;
			$display("tx_full never went high while the queue was being filled");
		end
		if (pending != 0) begin
			errors++;
			$display("%0d expected words never came out of the receiver", pending);
		end
		$display("Errors: %0d bench, %0d checker", errors, check_errors);
		if (errors == 0 && check_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- link_8b9b.f
rtl/link_8b9b_pkg.sv
rtl/tx_word_if.sv
rtl/tx_word_queue.sv
rtl/tx_framer_8b9b.sv
rtl/oversampling_rx_8b9b.sv
rtl/link_8b9b_top.sv
bench/link_8b9b_asserts.sv
bench/link_8b9b_checker.sv
bench/link_8b9b_tb.sv

//--- Bender.yml
package:
  name: link_8b9b

sources:
  - files:
      - rtl/link_8b9b_pkg.sv
      - rtl/tx_word_if.sv
      - rtl/tx_word_queue.sv
      - rtl/tx_framer_8b9b.sv
      - rtl/oversampling_rx_8b9b.sv
      - rtl/link_8b9b_top.sv
  - target: test
    files:
      - bench/link_8b9b_asserts.sv
      - bench/link_8b9b_checker.sv
      - bench/link_8b9b_tb.sv
